// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_accel_cfg
RTL_TOP   ?= accel_cfg_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	elif ! grep -q "Result: PASSED" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: accel_cfg_pkg.sv
package accel_cfg_pkg;

    // Register counts per region
    localparam int MAIN_REGS        = 4;
    localparam int ACT_REGS         = 3;
    localparam int WEI_REGS         = 3;
    localparam int OUT_REGS         = 2;
    localparam int N_CFG_REGS       = MAIN_REGS + ACT_REGS + WEI_REGS + OUT_REGS;
    localparam int N_INTR_EN_WRITES = 2;
    localparam int N_CFG_WRITES     = N_CFG_REGS + N_INTR_EN_WRITES;
    localparam int N_ARGS           = 1 + N_CFG_REGS;

    typedef logic [31:0] axi_word_t;
    typedef logic [12:0] cfg_addr_t;
    typedef logic [$clog2(N_CFG_WRITES)-1:0] wr_idx_t;
    typedef axi_word_t [N_ARGS-1:0] arg_words_t;
    typedef logic [2:0] keep_t;

    // Accelerator register map
    localparam cfg_addr_t CONTROL_OFFSET     = 13'h000;
    localparam cfg_addr_t INTR_EN_OFFSET     = 13'h004;
    localparam cfg_addr_t INTR_STATUS_OFFSET = 13'h00C;
    localparam cfg_addr_t MAIN_BASE          = 13'h020;
    localparam cfg_addr_t ACT_BASE           = 13'h040;
    localparam cfg_addr_t WEI_BASE           = 13'h060;
    localparam cfg_addr_t OUT_BASE           = 13'h080;

    // Start word fields
    localparam int START_RUN_BIT    = 0;
    localparam int START_ENABLE_BIT = 1;
    localparam int START_SWAP_BIT   = 16;
    localparam int START_KEEP_LSB   = 17;

    // Command word fields
    localparam int CMD_NO_START_BIT = 0;
    localparam int CMD_KEEP_LSB     = 1;

    typedef enum logic [2:0] {
        REG_MAIN,
        REG_ACT,
        REG_WEI,
        REG_OUT,
        REG_INTR
    } region_t;

    typedef enum logic [1:0] {
        WR_NONE,
        WR_CFG,
        WR_START,
        WR_CLEAR
    } wr_kind_t;

    typedef enum logic [3:0] {
        S_IDLE,
        S_LOAD,
        S_SEND_CFG,
        S_SYNC_RESP,
        S_SEND_START,
        S_WAIT_START_RESP,
        S_WAIT_ACC,
        S_SEND_CLEAR,
        S_WAIT_CLEAR_RESP,
        S_FINISH
    } seq_state_t;

endpackage

// File: accel_cfg_top.sv
`timescale 1ns/1ps

module accel_cfg_top
    import accel_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       fsm_start,
    input  arg_words_t args,
    input  logic       acc_irq,
    output logic       fsm_done,
    output logic       irq_out,
    output logic       awvalid,
    input  logic       awready,
    output axi_word_t  awaddr,
    output logic [2:0] awprot,
    output logic       wvalid,
    input  logic       wready,
    output axi_word_t  wdata,
    output logic [3:0] wstrb,
    input  logic       bvalid,
    output logic       bready
);

    wr_kind_t  wr_kind;
    logic      cfg_restart;
    logic      cfg_step;
    logic      sync_start;
    logic      resp_wait;
    logic      start_run;
    keep_t     keep;
    logic      beat_done;
    cfg_addr_t cfg_addr;
    wr_idx_t   cfg_idx;
    logic      cfg_intr_en;
    logic      cfg_last;
    logic      sync_busy;

    cfg_sequencer_fsm u_fsm (
        .clk         (clk),
        .rst         (rst),
        .fsm_start   (fsm_start),
        .acc_irq     (acc_irq),
        .cmd_word    (args[0]),
        .beat_done   (beat_done),
        .cfg_last    (cfg_last),
        .sync_busy   (sync_busy),
        .bvalid      (bvalid),
        .wr_kind     (wr_kind),
        .cfg_restart (cfg_restart),
        .cfg_step    (cfg_step),
        .sync_start  (sync_start),
        .resp_wait   (resp_wait),
        .start_run   (start_run),
        .keep        (keep),
        .fsm_done    (fsm_done),
        .irq_out     (irq_out)
    );

    cfg_addr_gen u_addr_gen (
        .clk         (clk),
        .rst         (rst),
        .cfg_restart (cfg_restart),
        .cfg_step    (cfg_step),
        .cfg_addr    (cfg_addr),
        .cfg_idx     (cfg_idx),
        .cfg_intr_en (cfg_intr_en),
        .cfg_last    (cfg_last)
    );

    axil_write_port u_write_port (
        .clk         (clk),
        .rst         (rst),
        .wr_kind     (wr_kind),
        .cfg_addr    (cfg_addr),
        .cfg_idx     (cfg_idx),
        .cfg_intr_en (cfg_intr_en),
        .args        (args),
        .start_run   (start_run),
        .keep        (keep),
        .resp_wait   (resp_wait),
        .sync_busy   (sync_busy),
        .awready     (awready),
        .wready      (wready),
        .bvalid      (bvalid),
        .awvalid     (awvalid),
        .awaddr      (awaddr),
        .awprot      (awprot),
        .wvalid      (wvalid),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .bready      (bready),
        .beat_done   (beat_done)
    );

    wresp_counter u_wresp_counter (
        .clk        (clk),
        .rst        (rst),
        .sync_start (sync_start),
        .bvalid     (bvalid),
        .bready     (bready),
        .sync_busy  (sync_busy)
    );

endmodule

// File: axil_write_port.sv
`timescale 1ns/1ps

module axil_write_port
    import accel_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  wr_kind_t   wr_kind,
    input  cfg_addr_t  cfg_addr,
    input  wr_idx_t    cfg_idx,
    input  logic       cfg_intr_en,
    input  arg_words_t args,
    input  logic       start_run,
    input  keep_t      keep,
    input  logic       resp_wait,
    input  logic       sync_busy,
    input  logic       awready,
    input  logic       wready,
    input  logic       bvalid,
    output logic       awvalid,
    output axi_word_t  awaddr,
    output logic [2:0] awprot,
    output logic       wvalid,
    output axi_word_t  wdata,
    output logic [3:0] wstrb,
    output logic       bready,
    output logic       beat_done
);

    logic      aw_sent;
    logic      w_sent;
    logic      active;
    cfg_addr_t addr_sel;
    wr_idx_t   arg_idx;

    assign active    = (wr_kind != WR_NONE);
    assign awvalid   = active && !aw_sent;
    assign wvalid    = active && !w_sent;
    // Beat ends when the later half is accepted
    assign beat_done = active && (aw_sent || awready) && (w_sent || wready);

    always_ff @(posedge clk) begin
        if (rst || beat_done) begin
            aw_sent <= 1'b0;
            w_sent  <= 1'b0;
        end else begin
            if (awvalid && awready) begin
                aw_sent <= 1'b1;
            end
            if (wvalid && wready) begin
                w_sent <= 1'b1;
            end
        end
    end

    // Word 0 is the command, so config values start at word 1
    assign arg_idx = cfg_idx + wr_idx_t'(1);

    always_comb begin
        addr_sel = '0;
        wdata    = '0;
        case (wr_kind)
            WR_CFG: begin
                addr_sel = cfg_addr;
                if (cfg_intr_en) begin
                    wdata = 32'd1;
                end else begin
                    wdata = args[arg_idx];
                end
            end
            WR_START: begin
                addr_sel                     = CONTROL_OFFSET;
                wdata[START_RUN_BIT]         = start_run;
                wdata[START_ENABLE_BIT]      = 1'b1;
                wdata[START_SWAP_BIT]        = 1'b1;
                wdata[START_KEEP_LSB +: 3]   = keep;
            end
            WR_CLEAR: begin
                addr_sel = INTR_STATUS_OFFSET;
                wdata    = 32'd1;
            end
            default: ;
        endcase
    end

    assign awaddr = {19'd0, addr_sel};
    assign awprot = 3'd0;
    assign wstrb  = 4'hF;
    assign bready = resp_wait || sync_busy;

    a_aw_stable: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else $error("awaddr changed while waiting for awready");

    a_w_stable: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(wdata))
        else $error("wdata changed while waiting for wready");

endmodule

// File: cfg_addr_gen.sv
`timescale 1ns/1ps

module cfg_addr_gen
    import accel_cfg_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      cfg_restart,
    input  logic      cfg_step,
    output cfg_addr_t cfg_addr,
    output wr_idx_t   cfg_idx,
    output logic      cfg_intr_en,
    output logic      cfg_last
);

    region_t region;
    // Writes left in the current region, minus one
    wr_idx_t remain;

    always_ff @(posedge clk) begin
        if (rst || cfg_restart) begin
            region   <= REG_MAIN;
            remain   <= wr_idx_t'(MAIN_REGS - 1);
            cfg_addr <= MAIN_BASE;
            cfg_idx  <= '0;
        end else if (cfg_step && !cfg_last) begin
            cfg_idx <= cfg_idx + wr_idx_t'(1);
            if (remain == '0) begin
                case (region)
                    REG_MAIN: begin
                        region   <= REG_ACT;
                        remain   <= wr_idx_t'(ACT_REGS - 1);
                        cfg_addr <= ACT_BASE;
                    end
                    REG_ACT: begin
                        region   <= REG_WEI;
                        remain   <= wr_idx_t'(WEI_REGS - 1);
                        cfg_addr <= WEI_BASE;
                    end
                    REG_WEI: begin
                        region   <= REG_OUT;
                        remain   <= wr_idx_t'(OUT_REGS - 1);
                        cfg_addr <= OUT_BASE;
                    end
                    // Interrupt enables close the burst
                    default: begin
                        region   <= REG_INTR;
                        remain   <= wr_idx_t'(N_INTR_EN_WRITES - 1);
                        cfg_addr <= INTR_EN_OFFSET;
                    end
                endcase
            end else begin
                remain   <= remain - wr_idx_t'(1);
                cfg_addr <= cfg_addr + cfg_addr_t'(4);
            end
        end
    end

    assign cfg_intr_en = (region == REG_INTR);
    assign cfg_last    = (region == REG_INTR) && (remain == '0);

    a_idx_range: assert property (@(posedge clk) disable iff (rst)
        cfg_idx < wr_idx_t'(N_CFG_WRITES))
        else $error("cfg_idx out of range");

    // Region walk and write index must agree on the burst end
    a_last_idx: assert property (@(posedge clk) disable iff (rst)
        cfg_last |-> cfg_idx == wr_idx_t'(N_CFG_WRITES - 1))
        else $error("cfg_last raised at the wrong write index");

endmodule

// File: cfg_sequencer_fsm.sv
`timescale 1ns/1ps

module cfg_sequencer_fsm
    import accel_cfg_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      fsm_start,
    input  logic      acc_irq,
    input  axi_word_t cmd_word,
    input  logic      beat_done,
    input  logic      cfg_last,
    input  logic      sync_busy,
    input  logic      bvalid,
    output wr_kind_t  wr_kind,
    output logic      cfg_restart,
    output logic      cfg_step,
    output logic      sync_start,
    output logic      resp_wait,
    output logic      start_run,
    output keep_t     keep,
    output logic      fsm_done,
    output logic      irq_out
);

    seq_state_t state;
    axi_word_t  cmd_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= S_IDLE;
            fsm_done <= 1'b0;
        end else begin
            fsm_done <= (state == S_FINISH);
            case (state)
                S_IDLE: begin
                    if (fsm_start) begin
                        state <= S_LOAD;
                    end
                end
                S_LOAD: state <= S_SEND_CFG;
                S_SEND_CFG: begin
                    if (beat_done && cfg_last) begin
                        state <= S_SYNC_RESP;
                    end
                end
                // All configuration responses must be back before the start word
                S_SYNC_RESP: begin
                    if (!sync_busy) begin
                        state <= S_SEND_START;
                    end
                end
                S_SEND_START: begin
                    if (beat_done) begin
                        state <= S_WAIT_START_RESP;
                    end
                end
                S_WAIT_START_RESP: begin
                    if (bvalid) begin
                        state <= start_run ? S_WAIT_ACC : S_FINISH;
                    end
                end
                S_WAIT_ACC: begin
                    if (acc_irq) begin
                        state <= S_SEND_CLEAR;
                    end
                end
                S_SEND_CLEAR: begin
                    if (beat_done) begin
                        state <= S_WAIT_CLEAR_RESP;
                    end
                end
                S_WAIT_CLEAR_RESP: begin
                    if (bvalid) begin
                        state <= S_FINISH;
                    end
                end
                S_FINISH: state <= S_IDLE;
                default:  state <= S_IDLE;
            endcase
        end
    end

    // Command word captured once per sequence
    always_ff @(posedge clk) begin
        if (state == S_LOAD) begin
            cmd_q <= cmd_word;
        end
    end

    always_comb begin
        case (state)
            S_SEND_CFG:   wr_kind = WR_CFG;
            S_SEND_START: wr_kind = WR_START;
            S_SEND_CLEAR: wr_kind = WR_CLEAR;
            default:      wr_kind = WR_NONE;
        endcase
    end

    assign cfg_restart = (state == S_LOAD);
    assign sync_start  = (state == S_LOAD);
    assign cfg_step    = (state == S_SEND_CFG) && beat_done;
    assign resp_wait   = (state == S_WAIT_START_RESP) || (state == S_WAIT_CLEAR_RESP);
    assign start_run   = !cmd_q[CMD_NO_START_BIT];
    assign keep        = cmd_q[CMD_KEEP_LSB +: 3];

    // Interrupt passes through only while idle
    assign irq_out = (state == S_IDLE) && acc_irq;

    a_done_single: assert property (@(posedge clk) disable iff (rst)
        fsm_done |=> !fsm_done)
        else $error("fsm_done high on two consecutive cycles");

endmodule

// File: tb.f
accel_cfg_pkg.sv
cfg_sequencer_fsm.sv
cfg_addr_gen.sv
axil_write_port.sv
wresp_counter.sv
accel_cfg_top.sv
tb_accel_cfg.sv

// File: tb_accel_cfg.sv
`timescale 1ns/1ps

module tb_accel_cfg
    import accel_cfg_pkg::*;
;

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 8;
    localparam int N_TESTS         = 5;
    localparam int MAX_DELAY       = 4;
    localparam int WATCHDOG_CYCLES = N_TESTS * 14 * MAX_DELAY * 4;
    localparam int LOG_DEPTH       = 128;
    localparam logic [31:0] SEED   = 32'hdcd832f3;

    logic       clk = 1'b0;
    logic       rst = 1'b1;
    logic       fsm_start = 1'b0;
    arg_words_t args = '0;
    logic       acc_irq = 1'b0;
    logic       awready = 1'b0;
    logic       wready = 1'b0;
    logic       bvalid = 1'b0;
    logic       fsm_done;
    logic       irq_out;
    logic       awvalid;
    axi_word_t  awaddr;
    logic [2:0] awprot;
    logic       wvalid;
    axi_word_t  wdata;
    logic [3:0] wstrb;
    logic       bready;

    // Slave model state and write log
    logic        backpressure = 1'b0;
    logic [31:0] slave_rng = SEED;
    logic [31:0] arg_rng = SEED;
    int          aw_delay, w_delay, b_delay;
    int          aw_total, w_total, b_total;
    axi_word_t   addr_log [LOG_DEPTH];
    axi_word_t   data_log [LOG_DEPTH];
    int          aw_bcnt_log [LOG_DEPTH];
    int          w_bcnt_log [LOG_DEPTH];
    int          value_errors = 0;
    int          other_errors = 0;

    accel_cfg_top UUT (
        .clk(clk), .rst(rst), .fsm_start(fsm_start), .args(args), .acc_irq(acc_irq),
        .fsm_done(fsm_done), .irq_out(irq_out),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr), .awprot(awprot),
        .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
        .bvalid(bvalid), .bready(bready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Slave with random ready and response delays that logs every accepted half
    always @(posedge clk) begin
        int d;
        if (rst) begin
            awready  <= 1'b1;
            wready   <= 1'b1;
            bvalid   <= 1'b0;
            aw_delay <= 0;
            w_delay  <= 0;
            b_delay  <= 0;
            aw_total <= 0;
            w_total  <= 0;
            b_total  <= 0;
        end else begin
            if (awvalid && awready) begin
                check_hex("awprot", 32'(awprot), 32'h0);
                addr_log[aw_total]    <= awaddr;
                aw_bcnt_log[aw_total] <= b_total;
                aw_total              <= aw_total + 1;
                slave_rng = xorshift32(slave_rng);
                d = backpressure ? int'(slave_rng % (MAX_DELAY + 1)) : 0;
                aw_delay <= d;
                awready  <= (d == 0);
            end else if (awvalid) begin
                if (aw_delay == 0) awready <= 1'b1;
                else aw_delay <= aw_delay - 1;
            end
            if (wvalid && wready) begin
                check_hex("wstrb", 32'(wstrb), 32'hF);
                data_log[w_total]   <= wdata;
                w_bcnt_log[w_total] <= b_total;
                w_total             <= w_total + 1;
                slave_rng = xorshift32(slave_rng);
                d = backpressure ? int'(slave_rng % (MAX_DELAY + 1)) : 0;
                w_delay <= d;
                wready  <= (d == 0);
            end else if (wvalid) begin
                if (w_delay == 0) wready <= 1'b1;
                else w_delay <= w_delay - 1;
            end
            // One response owed per write with both halves accepted
            if (bvalid && bready) begin
                b_total <= b_total + 1;
                bvalid  <= 1'b0;
                slave_rng = xorshift32(slave_rng);
                b_delay <= backpressure ? int'(slave_rng % (MAX_DELAY + 1)) : 0;
            end else if (!bvalid && b_total < aw_total && b_total < w_total) begin
                if (b_delay == 0) bvalid <= 1'b1;
                else b_delay <= b_delay - 1;
            end
        end
    end

    task automatic check_hex(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            value_errors++;
            $display("** Error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond) else begin
            other_errors++;
            $display("Error: %s", msg);
        end
    endtask

    // Register map walk through main, act, wei and out regions, then the two enables
    function automatic logic [31:0] exp_cfg_addr(input int k);
        int bases [4] = '{'h020, 'h040, 'h060, 'h080};
        int counts [4] = '{4, 3, 3, 2};
        int rem;
        rem = k;
        for (int r = 0; r < 4; r++) begin
            if (rem < counts[r]) return 32'(bases[r] + 4 * rem);
            rem -= counts[r];
        end
        return 32'('h004 + 4 * rem);
    endfunction

    function automatic logic [31:0] exp_start_word(input logic no_start, input keep_t k);
        logic [31:0] w;
        w = '0;
        w[0]     = !no_start;
        w[1]     = 1'b1;
        w[16]    = 1'b1;
        w[19:17] = k;
        return w;
    endfunction

    // One cycle of a running sequence; irq_out must stay low until done
    task automatic tick(inout int done_count);
        @(posedge clk);
        if (fsm_done) done_count++;
        else if (done_count == 0) check_hex("irq_out", 32'(irq_out), 32'd0);
    endtask

    task automatic check_burst(input int base, input int b_base, input arg_words_t a,
                               input logic no_start, input keep_t k);
        int n_exp;
        n_exp = no_start ? 15 : 16;
        check_true(aw_total - base == n_exp,
                   $sformatf("%0d addresses accepted, expected %0d", aw_total - base, n_exp));
        check_true(w_total - base == n_exp,
                   $sformatf("%0d data words accepted, expected %0d", w_total - base, n_exp));
        check_true(b_total - b_base == n_exp,
                   $sformatf("%0d responses taken, expected %0d", b_total - b_base, n_exp));
        for (int i = 0; i < 14; i++) begin
            check_hex($sformatf("awaddr[%0d]", i), addr_log[base + i], exp_cfg_addr(i));
            check_hex($sformatf("wdata[%0d]", i), data_log[base + i],
                      i < 12 ? a[i + 1] : 32'd1);
        end
        check_hex("start awaddr", addr_log[base + 14], 32'h000);
        check_hex("start wdata", data_log[base + 14], exp_start_word(no_start, k));
        check_true(aw_bcnt_log[base + 14] >= b_base + 14 && w_bcnt_log[base + 14] >= b_base + 14,
                   "start write accepted before all configuration responses returned");
        if (!no_start) begin
            check_hex("clear awaddr", addr_log[base + 15], 32'h00C);
            check_hex("clear wdata", data_log[base + 15], 32'd1);
        end
    endtask

    task automatic run_sequence(input logic no_start, input keep_t k);
        arg_words_t a;
        int         base, b_base, done_count;
        base       = aw_total;
        b_base     = b_total;
        done_count = 0;
        arg_rng = xorshift32(arg_rng);
        a[0] = {arg_rng[31:4], k, no_start};
        for (int i = 1; i < N_ARGS; i++) begin
            arg_rng = xorshift32(arg_rng);
            a[i] = arg_rng;
        end
        args      <= a;
        fsm_start <= 1'b1;
        @(posedge clk);
        fsm_start <= 1'b0;
        // Interrupt held high during a no-start run must not leak out
        if (no_start) acc_irq <= 1'b1;
        if (!no_start) begin
            while (b_total < b_base + 15) tick(done_count);
            repeat (5) tick(done_count);
            check_true(aw_total == base + 15 && w_total == base + 15,
                       "clear write issued before the interrupt");
            check_true(done_count == 0, "fsm_done pulsed before the interrupt");
            acc_irq <= 1'b1;
            while (aw_total < base + 16 || w_total < base + 16) tick(done_count);
            acc_irq <= 1'b0;
        end
        while (done_count == 0) tick(done_count);
        acc_irq <= 1'b0;
        repeat (4) tick(done_count);
        check_true(done_count == 1,
                   $sformatf("fsm_done pulsed %0d times, expected once", done_count));
        check_burst(base, b_base, a, no_start, k);
    endtask

    task automatic test_irq_forwarding();
        for (int i = 0; i < 4; i++) begin
            acc_irq <= !i[0];
            @(posedge clk);
            check_hex("irq_out", 32'(irq_out), 32'(!i[0]));
        end
        acc_irq <= 1'b0;
        @(posedge clk);
    endtask

    task automatic test_run_mode();
        backpressure <= 1'b0;
        run_sequence(1'b0, 3'b101);
    endtask

    task automatic test_no_start();
        backpressure <= 1'b0;
        run_sequence(1'b1, 3'b010);
    endtask

    task automatic test_backpressure_run();
        backpressure <= 1'b1;
        run_sequence(1'b0, 3'b111);
    endtask

    task automatic test_backpressure_no_start();
        backpressure <= 1'b1;
        run_sequence(1'b1, 3'b001);
    endtask

    initial begin
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        test_irq_forwarding();
        test_run_mode();
        test_no_start();
        test_backpressure_run();
        test_backpressure_no_start();
        $display("Errors: value %0d, other %0d", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        repeat (RESET_CYCLES + WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: sequence did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Errors: value %0d, other %0d", value_errors, other_errors);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// File: wresp_counter.sv
`timescale 1ns/1ps

module wresp_counter
    import accel_cfg_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic sync_start,
    input  logic bvalid,
    input  logic bready,
    output logic sync_busy
);

    wr_idx_t count;
    logic    resp_fire;

    assign resp_fire = bvalid && bready;

    always_ff @(posedge clk) begin
        if (rst) begin
            sync_busy <= 1'b0;
            count     <= '0;
        end else if (sync_start) begin
            sync_busy <= 1'b1;
            count     <= '0;
        end else if (sync_busy && resp_fire) begin
            count <= count + wr_idx_t'(1);
            // Last configuration response
            if (count == wr_idx_t'(N_CFG_WRITES - 1)) begin
                sync_busy <= 1'b0;
            end
        end
    end

    // No stray response may follow the final counted one
    a_no_extra_resp: assert property (@(posedge clk) disable iff (rst)
        sync_busy && resp_fire && count == wr_idx_t'(N_CFG_WRITES - 1) |=> !resp_fire)
        else $error("write response after the burst count was full");

endmodule
